// ==== src/gpio_pkg.sv ====
// GPIO subsystem shared definitions
// Bus widths, response codes, address map, register offsets
// and the request and response structs of the AXI4-Lite style bus

package gpio_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Response codes
  // EXOKAY is never produced
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  localparam addr_t SLV0_BASE = 16'h0000;
  localparam addr_t SLV1_BASE = 16'h1000;
  // 4 KB window per slave
  localparam int unsigned WIN_W = 12;

  // Register offsets inside a window
  localparam logic [3:0] REG_OE   = 4'h0;
  localparam logic [3:0] REG_OUT  = 4'h4;
  localparam logic [3:0] REG_IN   = 4'h8;
  localparam logic [3:0] REG_EDGE = 4'hC;

  //////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////

  // Master to slave
  typedef struct packed {
    logic  aw_valid;
    addr_t aw_addr;
    logic  w_valid;
    data_t w_data;
    logic  b_ready;
    logic  ar_valid;
    addr_t ar_addr;
    logic  r_ready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_e b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_e r_resp;
  } axil_rsp_t;

endpackage

// ==== src/axil_decoder.sv ====
// AXI4-Lite style address decoder
// Routes one host bus to two slaves by the address bits above the window
// and answers unmapped accesses with a decode error

`timescale 1ns/1ps

module axil_decoder (
  input  logic                bus,
  input  logic                reset,
  input  gpio_pkg::axil_req_t host_req,
  output gpio_pkg::axil_rsp_t host_rsp,
  output gpio_pkg::axil_req_t slv_req [2],
  input  gpio_pkg::axil_rsp_t slv_rsp [2]
);

  // One hot slave hit from the address bits above the window
  function automatic logic [1:0] decode(input gpio_pkg::addr_t addr);
    logic [1:0] hit;
    hit[0] = addr[gpio_pkg::ADDR_W-1:gpio_pkg::WIN_W] ==
             gpio_pkg::SLV0_BASE[gpio_pkg::ADDR_W-1:gpio_pkg::WIN_W];
    hit[1] = addr[gpio_pkg::ADDR_W-1:gpio_pkg::WIN_W] ==
             gpio_pkg::SLV1_BASE[gpio_pkg::ADDR_W-1:gpio_pkg::WIN_W];
    return hit;
  endfunction

  //////////////////////////////////////////////////
  // Decode and selection state
  //////////////////////////////////////////////////

  logic [1:0] wr_hit;
  logic [1:0] rd_hit;
  logic       wr_miss;
  logic       rd_miss;

  // Per direction selection held while a response is pending
  logic       wr_busy;
  logic       wr_idx;
  logic       wr_err;
  logic       rd_busy;
  logic       rd_idx;
  logic       rd_err;

  // Error responder valids
  logic       err_b_valid;
  logic       err_r_valid;

  logic       wr_acc;
  logic       rd_acc;

  assign wr_hit  = decode(host_req.aw_addr);
  assign rd_hit  = decode(host_req.ar_addr);
  assign wr_miss = ~|wr_hit;
  assign rd_miss = ~|rd_hit;

  // Request accepted on the host side
  assign wr_acc = host_req.aw_valid & host_rsp.aw_ready;
  assign rd_acc = host_req.ar_valid & host_rsp.ar_ready;

  //////////////////////////////////////////////////
  // Request forwarding
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      // Addresses and data go to both slaves
      slv_req[i] = host_req;
      // Valid only toward the selected slave and only when idle
      slv_req[i].aw_valid = host_req.aw_valid & ~wr_busy & wr_hit[i];
      slv_req[i].w_valid  = host_req.w_valid & ~wr_busy & wr_hit[i];
      slv_req[i].ar_valid = host_req.ar_valid & ~rd_busy & rd_hit[i];
      // Response ready only toward the slave that owns the response
      slv_req[i].b_ready  = host_req.b_ready & wr_busy & ~wr_err & (wr_idx == i[0]);
      slv_req[i].r_ready  = host_req.r_ready & rd_busy & ~rd_err & (rd_idx == i[0]);
    end
  end

  //////////////////////////////////////////////////
  // Host response
  //////////////////////////////////////////////////

  always_comb begin
    // Ready from the selected slave
    // Unmapped writes need AW and W together, like the slaves
    host_rsp.aw_ready = ~wr_busy & (wr_miss ? host_req.aw_valid & host_req.w_valid :
                                              slv_rsp[wr_hit[1]].aw_ready);
    host_rsp.w_ready  = ~wr_busy & (wr_miss ? host_req.aw_valid & host_req.w_valid :
                                              slv_rsp[wr_hit[1]].w_ready);
    host_rsp.ar_ready = ~rd_busy & (rd_miss ? 1'b1 : slv_rsp[rd_hit[1]].ar_ready);

    // B routed by the stored selection
    host_rsp.b_valid = wr_busy & (wr_err ? err_b_valid : slv_rsp[wr_idx].b_valid);
    host_rsp.b_resp  = wr_err ? gpio_pkg::RESP_DECERR : slv_rsp[wr_idx].b_resp;

    // R routed by the stored selection
    host_rsp.r_valid = rd_busy & (rd_err ? err_r_valid : slv_rsp[rd_idx].r_valid);
    host_rsp.r_data  = rd_err ? '0 : slv_rsp[rd_idx].r_data;
    host_rsp.r_resp  = rd_err ? gpio_pkg::RESP_DECERR : slv_rsp[rd_idx].r_resp;
  end

  //////////////////////////////////////////////////
  // Selection registers and error responder
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      wr_busy     <= 1'b0;
      wr_idx      <= 1'b0;
      wr_err      <= 1'b0;
      err_b_valid <= 1'b0;
    end else begin
      if (wr_acc) begin
        wr_busy <= 1'b1;
        wr_idx  <= wr_hit[1];
        wr_err  <= wr_miss;
      end else if (host_rsp.b_valid & host_req.b_ready) begin
        wr_busy <= 1'b0;
      end
      // Error B one cycle after acceptance, held until taken
      err_b_valid <= (wr_acc & wr_miss) | (err_b_valid & ~host_req.b_ready);
    end
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      rd_busy     <= 1'b0;
      rd_idx      <= 1'b0;
      rd_err      <= 1'b0;
      err_r_valid <= 1'b0;
    end else begin
      if (rd_acc) begin
        rd_busy <= 1'b1;
        rd_idx  <= rd_hit[1];
        rd_err  <= rd_miss;
      end else if (host_rsp.r_valid & host_req.r_ready) begin
        rd_busy <= 1'b0;
      end
      // Error R mirrors the write side
      err_r_valid <= (rd_acc & rd_miss) | (err_r_valid & ~host_req.r_ready);
    end
  end

endmodule

// ==== src/gpio_in_capture.sv ====
// GPIO input capture
// Two stage pin synchronizer with rising edge detection
// and sticky edge status cleared by write one

`timescale 1ns/1ps

module gpio_in_capture #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             bus,
  input  logic             reset,
  input  logic [WIDTH-1:0] in,
  input  logic [WIDTH-1:0] clear,
  output logic [WIDTH-1:0] level,
  output logic [WIDTH-1:0] edges
);

  // First synchronizer stage
  logic [WIDTH-1:0] sync_q;
  // Level one cycle back
  logic [WIDTH-1:0] level_q;
  logic [WIDTH-1:0] rise;

  // Low to high on the synchronized level
  assign rise = level & ~level_q;

  always_ff @(posedge bus) begin
    if (reset) begin
      sync_q  <= '0;
      level   <= '0;
      level_q <= '0;
      edges   <= '0;
    end else begin
      // Pins reach level after two edges
      sync_q  <= in;
      level   <= sync_q;
      level_q <= level;
      // New edge wins over a clear in the same cycle
      edges   <= (edges & ~clear) | rise;
    end
  end

endmodule

// ==== src/gpio.sv ====
// GPIO register block
// Output enable and output value registers, synchronized input,
// rising edge status and AXI4-Lite style write and read responses

`timescale 1ns/1ps

module gpio #(
  parameter int unsigned WIDTH = 8
) (
  input  logic                bus,
  input  logic                reset,
  input  gpio_pkg::axil_req_t regs_req,
  output gpio_pkg::axil_rsp_t regs_rsp,
  output logic [WIDTH-1:0]    oe,
  output logic [WIDTH-1:0]    out,
  input  logic [WIDTH-1:0]    in
);

  // Offset lies in the register area at the bottom of the window
  function automatic logic in_regs(input gpio_pkg::addr_t addr);
    return addr[gpio_pkg::WIN_W-1:4] == '0;
  endfunction

  logic                  wr_en;
  logic                  rd_en;
  logic                  b_valid;
  logic                  r_valid;
  gpio_pkg::data_t       r_data;
  logic [3:0]            wr_off;
  logic [3:0]            rd_off;
  logic [WIDTH-1:0]      edge_clear;
  logic [WIDTH-1:0]      in_level;
  logic [WIDTH-1:0]      in_edges;

  assign wr_off = regs_req.aw_addr[3:0];
  assign rd_off = regs_req.ar_addr[3:0];

  //////////////////////////////////////////////////
  // Input path
  //////////////////////////////////////////////////

  gpio_in_capture #(
    .WIDTH (WIDTH)
  ) capture (
    .bus   (bus),
    .reset (reset),
    .in    (in),
    .clear (edge_clear),
    .level (in_level),
    .edges (in_edges)
  );

  //////////////////////////////////////////////////
  // Write access
  //////////////////////////////////////////////////

  // AW and W together, one B in flight
  assign wr_en = regs_req.aw_valid & regs_req.w_valid & ~b_valid;

  // Write one to clear edge status
  assign edge_clear = (wr_en && in_regs(regs_req.aw_addr) && wr_off == gpio_pkg::REG_EDGE) ?
                      regs_req.w_data[WIDTH-1:0] : '0;

  always_ff @(posedge bus) begin
    if (reset) begin
      oe  <= '0;
      out <= '0;
    end else if (wr_en && in_regs(regs_req.aw_addr)) begin
      // Pins follow on the transfer edge
      if (wr_off == gpio_pkg::REG_OE)
        oe <= regs_req.w_data[WIDTH-1:0];
      if (wr_off == gpio_pkg::REG_OUT)
        out <= regs_req.w_data[WIDTH-1:0];
    end
  end

  // B valid the edge after transfer, held until b_ready
  always_ff @(posedge bus) begin
    if (reset)
      b_valid <= 1'b0;
    else
      b_valid <= wr_en | (b_valid & ~regs_req.b_ready);
  end

  //////////////////////////////////////////////////
  // Read access
  //////////////////////////////////////////////////

  assign rd_en = regs_req.ar_valid & ~r_valid;

  // Read data sampled on the AR transfer edge
  always_ff @(posedge bus) begin
    if (rd_en) begin
      r_data <= '0;
      if (in_regs(regs_req.ar_addr)) begin
        case (rd_off)
          gpio_pkg::REG_OE:   r_data <= gpio_pkg::data_t'(oe);
          gpio_pkg::REG_OUT:  r_data <= gpio_pkg::data_t'(out);
          gpio_pkg::REG_IN:   r_data <= gpio_pkg::data_t'(in_level);
          gpio_pkg::REG_EDGE: r_data <= gpio_pkg::data_t'(in_edges);
          default:            r_data <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge bus) begin
    if (reset)
      r_valid <= 1'b0;
    else
      r_valid <= rd_en | (r_valid & ~regs_req.r_ready);
  end

  //////////////////////////////////////////////////
  // Response struct
  //////////////////////////////////////////////////

  always_comb begin
    regs_rsp.aw_ready = wr_en;
    regs_rsp.w_ready  = wr_en;
    regs_rsp.b_valid  = b_valid;
    // Unused offsets still answer OKAY
    regs_rsp.b_resp   = gpio_pkg::RESP_OKAY;
    regs_rsp.ar_ready = ~r_valid;
    regs_rsp.r_valid  = r_valid;
    regs_rsp.r_data   = r_data;
    regs_rsp.r_resp   = gpio_pkg::RESP_OKAY;
  end

endmodule

// ==== src/gpio_top.sv ====
// GPIO subsystem top level
// Host bus decoder feeding an 8 pin and a 16 pin GPIO block

`timescale 1ns/1ps

module gpio_top (
  input  logic                bus,
  input  logic                reset,
  input  gpio_pkg::axil_req_t host_req,
  output gpio_pkg::axil_rsp_t host_rsp,
  output logic [7:0]          port_a_oe,
  output logic [7:0]          port_a_out,
  input  logic [7:0]          port_a_in,
  output logic [15:0]         port_b_oe,
  output logic [15:0]         port_b_out,
  input  logic [15:0]         port_b_in
);

  // Decoder to slave buses
  gpio_pkg::axil_req_t slv_req [2];
  gpio_pkg::axil_rsp_t slv_rsp [2];

  axil_decoder decoder (
    .bus      (bus),
    .reset    (reset),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .slv_req  (slv_req),
    .slv_rsp  (slv_rsp)
  );

  // Slave 0 at 0x0000
  gpio #(
    .WIDTH (8)
  ) port_a (
    .bus      (bus),
    .reset    (reset),
    .regs_req (slv_req[0]),
    .regs_rsp (slv_rsp[0]),
    .oe       (port_a_oe),
    .out      (port_a_out),
    .in       (port_a_in)
  );

  // Slave 1 at 0x1000
  gpio #(
    .WIDTH (16)
  ) port_b (
    .bus      (bus),
    .reset    (reset),
    .regs_req (slv_req[1]),
    .regs_rsp (slv_rsp[1]),
    .oe       (port_b_oe),
    .out      (port_b_out),
    .in       (port_b_in)
  );

endmodule

// ==== bench/gpio_tb.sv ====
// GPIO subsystem testbench
// Table driven host bus accesses and pin stimulus with register and pin checks

`timescale 1ns/1ps

module gpio_tb;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_PIN} op_e;

  // One stimulus row
  typedef struct packed {
    op_e             op;
    gpio_pkg::addr_t addr;
    gpio_pkg::data_t wdata;
    logic [7:0]      pa;
    logic [15:0]     pb;
    gpio_pkg::data_t exp;
    gpio_pkg::resp_e resp;
    logic            bp;
  } row_t;

  logic                bus;
  logic                reset;
  gpio_pkg::axil_req_t host_req;
  gpio_pkg::axil_rsp_t host_rsp;
  logic [7:0]          port_a_oe;
  logic [7:0]          port_a_out;
  logic [7:0]          port_a_in;
  logic [15:0]         port_b_oe;
  logic [15:0]         port_b_out;
  logic [15:0]         port_b_in;

  row_t        rows [$];
  // Expected {a_oe, a_out, b_oe, b_out}
  logic [47:0] exp_pins;
  integer      seed = 32'hdb90_c334;
  int          max_wait = 200;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  string       cond_name [4] = '{"AW and W ready", "B valid", "AR ready", "R valid"};

  gpio_top dut (.*);

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic report(input logic ok, input string what);
    if (ok) begin
      pass_cnt++;
      $display("[PASS] %s", what);
    end else begin
      fail_cnt++;
      $display("[FAIL] %0t %s", $time, what);
    end
  endtask

  task automatic check_resp(input string what, input gpio_pkg::resp_e got,
                            input gpio_pkg::resp_e exp);
    report(got === exp, $sformatf("%s resp %0d expected %0d", what, got, exp));
  endtask

  task automatic check_data(input string what, input gpio_pkg::data_t got,
                            input gpio_pkg::data_t exp);
    report(got === exp, $sformatf("%s data %h expected %h", what, got, exp));
  endtask

  task automatic check_pins(input string what, input logic [47:0] got,
                            input logic [47:0] exp);
    report(got === exp, $sformatf("%s pins %h expected %h", what, got, exp));
  endtask

  //////////////////////////////////////////////////
  // Host bus driver
  //////////////////////////////////////////////////

  function automatic logic bus_cond(input int which);
    case (which)
      0: return host_rsp.aw_ready && host_rsp.w_ready;
      1: return host_rsp.b_valid;
      2: return host_rsp.ar_ready;
      default: return host_rsp.r_valid;
    endcase
  endfunction

  // Response fields that must hold while ready is low
  function automatic logic [34:0] rsp_view(input logic is_read);
    if (is_read)
      return {host_rsp.r_valid, host_rsp.r_resp, host_rsp.r_data};
    return {host_rsp.b_valid, host_rsp.b_resp, 32'h0};
  endfunction

  // Sampled mid cycle, so a hit means a transfer on the next edge
  task automatic wait_for(input int which, output logic ok);
    int n;
    n = 0;
    @(negedge bus);
    while (!bus_cond(which) && n < max_wait) begin
      @(negedge bus);
      n++;
    end
    ok = bus_cond(which);
    if (!ok) begin
      fail_cnt++;
      $display("Timed out after %0d cycles waiting for %s", max_wait, cond_name[which]);
    end
  endtask

  // Back-pressure for stall cycles, then take the response
  task automatic take_response(input logic is_read, input int stall);
    logic [34:0] held;
    held = rsp_view(is_read);
    repeat (stall) begin
      @(negedge bus);
      if (rsp_view(is_read) !== held) begin
        fail_cnt++;
        $display("[FAIL] %0t response changed while ready was low", $time);
      end
    end
    if (stall > 0) begin
      @(posedge bus);
      #1;
      host_req.b_ready = !is_read;
      host_req.r_ready = is_read;
    end
    @(posedge bus);
    #1;
    host_req.b_ready = 1'b0;
    host_req.r_ready = 1'b0;
  endtask

  task automatic axil_write(input gpio_pkg::addr_t addr, input gpio_pkg::data_t data,
                            input int stall, output gpio_pkg::resp_e resp);
    logic ok;
    @(posedge bus);
    #1;
    host_req.aw_valid = 1'b1;
    host_req.aw_addr  = addr;
    host_req.w_valid  = 1'b1;
    host_req.w_data   = data;
    host_req.b_ready  = (stall == 0);
    wait_for(0, ok);
    @(posedge bus);
    #1;
    host_req.aw_valid = 1'b0;
    host_req.w_valid  = 1'b0;
    if (ok)
      wait_for(1, ok);
    resp = host_rsp.b_resp;
    if (ok)
      take_response(1'b0, stall);
  endtask

  task automatic axil_read(input gpio_pkg::addr_t addr, input int stall,
                           output gpio_pkg::resp_e resp, output gpio_pkg::data_t data);
    logic ok;
    @(posedge bus);
    #1;
    host_req.ar_valid = 1'b1;
    host_req.ar_addr  = addr;
    host_req.r_ready  = (stall == 0);
    wait_for(2, ok);
    @(posedge bus);
    #1;
    host_req.ar_valid = 1'b0;
    if (ok)
      wait_for(3, ok);
    resp = host_rsp.r_resp;
    data = host_rsp.r_data;
    if (ok)
      take_response(1'b1, stall);
  endtask

  task automatic add_row(input op_e op, input gpio_pkg::addr_t addr,
                         input gpio_pkg::data_t wdata, input logic [7:0] pa,
                         input logic [15:0] pb, input gpio_pkg::data_t exp,
                         input logic err, input logic bp);
    gpio_pkg::resp_e resp;
    resp = err ? gpio_pkg::RESP_DECERR : gpio_pkg::RESP_OKAY;
    rows.push_back(row_t'{op, addr, wdata, pa, pb, exp, resp, bp});
  endtask

  //////////////////////////////////////////////////
  // Stimulus table and main loop
  //////////////////////////////////////////////////

  initial begin
    row_t            r;
    gpio_pkg::resp_e resp;
    gpio_pkg::data_t data;
    gpio_pkg::data_t rnd [4];
    gpio_pkg::data_t edge_a;
    gpio_pkg::data_t edge_b;
    string           tag;
    int              stall;
    host_req  = '0;
    port_a_in = '0;
    port_b_in = '0;
    reset     = 1'b1;
    exp_pins  = '0;
    foreach (rnd[i])
      rnd[i] = $random(seed);
    // Port A status cleared between the pin steps, so only new rising bits
    edge_a = 32'h0F & ~32'h5A;
    // Port B keeps sticky rising bits over both pin steps
    edge_b = 32'h1234 | (32'h8001 & ~32'h1234);

    // Output registers, truncated to the port width
    add_row(OP_WR, 16'h0000, rnd[0], '0, '0, '0, 0, 0);
    add_row(OP_RD, 16'h0000, '0, '0, '0, rnd[0] & 32'hFF, 0, 0);
    add_row(OP_WR, 16'h0004, rnd[1], '0, '0, '0, 0, 1);
    add_row(OP_RD, 16'h0004, '0, '0, '0, rnd[1] & 32'hFF, 0, 1);
    add_row(OP_WR, 16'h1000, rnd[2], '0, '0, '0, 0, 0);
    add_row(OP_RD, 16'h1000, '0, '0, '0, rnd[2] & 32'hFFFF, 0, 0);
    add_row(OP_WR, 16'h1004, rnd[3], '0, '0, '0, 0, 1);
    add_row(OP_RD, 16'h1004, '0, '0, '0, rnd[3] & 32'hFFFF, 0, 0);
    // Port A untouched by port B writes
    add_row(OP_RD, 16'h0000, '0, '0, '0, rnd[0] & 32'hFF, 0, 0);
    // Unmapped space
    add_row(OP_WR, 16'h2000, 32'hFFFF_FFFF, '0, '0, '0, 1, 0);
    add_row(OP_RD, 16'h2004, '0, '0, '0, '0, 1, 1);
    add_row(OP_WR, 16'hF004, 32'hFFFF_FFFF, '0, '0, '0, 1, 1);
    add_row(OP_RD, 16'h0004, '0, '0, '0, rnd[1] & 32'hFF, 0, 0);
    // Unused offsets
    add_row(OP_RD, 16'h0010, '0, '0, '0, '0, 0, 0);
    add_row(OP_WR, 16'h0010, 32'hFFFF_FFFF, '0, '0, '0, 0, 0);
    add_row(OP_RD, 16'h1010, '0, '0, '0, '0, 0, 0);
    // Input path and edge capture
    add_row(OP_PIN, '0, '0, 8'h5A, 16'h1234, '0, 0, 0);
    add_row(OP_RD, 16'h0008, '0, '0, '0, 32'h5A, 0, 0);
    add_row(OP_RD, 16'h1008, '0, '0, '0, 32'h1234, 0, 0);
    add_row(OP_RD, 16'h000C, '0, '0, '0, 32'h5A, 0, 0);
    // Falling bits of the next step land on cleared status bits
    add_row(OP_WR, 16'h000C, 32'h5A, '0, '0, '0, 0, 0);
    add_row(OP_PIN, '0, '0, 8'h0F, 16'h8001, '0, 0, 0);
    add_row(OP_RD, 16'h0008, '0, '0, '0, 32'h0F, 0, 0);
    add_row(OP_RD, 16'h000C, '0, '0, '0, edge_a, 0, 0);
    add_row(OP_WR, 16'h000C, 32'h04, '0, '0, '0, 0, 0);
    add_row(OP_RD, 16'h000C, '0, '0, '0, edge_a & ~32'h04, 0, 0);
    add_row(OP_RD, 16'h100C, '0, '0, '0, edge_b, 0, 0);
    add_row(OP_WR, 16'h100C, 32'h0234, '0, '0, '0, 0, 1);
    add_row(OP_RD, 16'h100C, '0, '0, '0, edge_b & ~32'h0234, 0, 1);
    add_row(OP_RD, 16'h1008, '0, '0, '0, 32'h8001, 0, 0);

    repeat (16) @(posedge bus);
    #1;
    reset = 1'b0;

    foreach (rows[i]) begin
      r = rows[i];
      tag = $sformatf("row %0d addr %h", i, r.addr);
      stall = 0;
      if (r.bp)
        stall = 2 + $unsigned($random(seed)) % 6;
      case (r.op)
        OP_PIN: begin
          @(posedge bus);
          #1;
          port_a_in = r.pa;
          port_b_in = r.pb;
          // Synchronizer and edge detector settle
          repeat (5) @(posedge bus);
        end
        OP_WR: begin
          axil_write(r.addr, r.wdata, stall, resp);
          check_resp(tag, resp, r.resp);
          // Only the four pin registers drive pins
          case (r.addr)
            16'h0000: exp_pins[47:40] = r.wdata[7:0];
            16'h0004: exp_pins[39:32] = r.wdata[7:0];
            16'h1000: exp_pins[31:16] = r.wdata[15:0];
            16'h1004: exp_pins[15:0]  = r.wdata[15:0];
            default: ;
          endcase
          check_pins(tag, {port_a_oe, port_a_out, port_b_oe, port_b_out}, exp_pins);
        end
        default: begin
          axil_read(r.addr, stall, resp, data);
          check_resp(tag, resp, r.resp);
          check_data(tag, data, r.exp);
        end
      endcase
    end

    $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== tb.f ====
src/gpio_pkg.sv
src/axil_decoder.sv
src/gpio_in_capture.sv
src/gpio.sv
src/gpio_top.sv
bench/gpio_tb.sv

// ==== Makefile ====
# Verilator build and run of the GPIO subsystem testbench
# make compile, make run, make clean

VERILATOR ?= verilator
TOP       ?= gpio_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
